// File: hdl/cluster_pkg.sv
// Widths, direction codes and link payloads shared by every module of the cluster
package cluster_pkg;

  // Four groups in a 2x2 arrangement; the XOR neighbour wiring relies on this
  localparam int unsigned NumGroups     = 4;
  localparam int unsigned GroupIdWidth  = 2;
  localparam int unsigned DataWidth     = 32;
  localparam int unsigned StrbWidth     = DataWidth / 8;
  // Top bits pick the group, the rest is the word inside the bank
  localparam int unsigned WordAddrWidth = 12;
  localparam int unsigned OffsetWidth   = WordAddrWidth - GroupIdWidth;

  // Partner group is the initiator index XOR this code
  typedef enum logic [1:0] {
    DirLocal     = 2'b00,
    DirEast      = 2'b01,
    DirNorth     = 2'b10,
    DirNortheast = 2'b11
  } dir_e;

  typedef struct packed {
    logic                   wen;
    logic [StrbWidth-1:0]   be;
    logic [OffsetWidth-1:0] offset;
    logic [DataWidth-1:0]   wdata;
  } tcdm_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] rdata;
  } tcdm_resp_t;

endpackage : cluster_pkg

// File: hdl/rst_gen_bypass.sv
// Cluster reset generator: asserts asynchronously, releases in sync with clk_i, bypassed for scan
`timescale 1ns/1ps

module rst_gen_bypass (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic testmode_i,
  output logic rst_n_o
);

  logic [1:0] sync_q;

  // Two-flop release, ones shift in after rst_n_i rises
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  // Tester drives reset directly in test mode
  assign rst_n_o = testmode_i ? rst_n_i : sync_q[1];

endmodule : rst_gen_bypass

// File: hdl/tcdm_bank.sv
// Single-port memory bank of one group, byte-enable writes and read data valid one cycle later
`timescale 1ns/1ps

module tcdm_bank #(
  parameter int unsigned BankWords = 256
) (
  input  logic                              clk_i,
  input  logic                              req_i,
  input  logic                              wen_i,
  input  logic [cluster_pkg::StrbWidth-1:0] be_i,
  input  logic [$clog2(BankWords)-1:0]      addr_i,
  input  logic [cluster_pkg::DataWidth-1:0] wdata_i,
  output logic [cluster_pkg::DataWidth-1:0] rdata_o
);
  import cluster_pkg::*;

  logic [DataWidth-1:0] mem_q [BankWords];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (wen_i) begin
        // Only the enabled bytes are touched
        for (int b = 0; b < StrbWidth; b++) begin
          if (be_i[b]) begin
            mem_q[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        // Read data stays put until the next read
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule : tcdm_bank

// File: hdl/link_reg.sv
// Two-entry valid/ready register slice placed on every link between groups, any payload type
`timescale 1ns/1ps

module link_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  payload_t   data_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic       push;
  logic       pop;

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  // Second entry keeps ready high while the consumer stalls for one cycle
  assign ready_o = (count_q != 2'd2);
  assign valid_o = (count_q != 2'd0);
  assign data_o  = data_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      count_q <= count_q + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      data_q[wr_ptr_q] <= data_i;
    end
  end

endmodule : link_reg

// File: hdl/cluster_group.sv
// One cluster group: core port routing, round-robin access to the local bank, response steering
`timescale 1ns/1ps

module cluster_group #(
  parameter int unsigned BankWords = 256
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  logic [cluster_pkg::GroupIdWidth-1:0]  group_id_i,
  // Core port
  input  logic                                  req_valid_i,
  output logic                                  req_ready_o,
  input  logic                                  req_wen_i,
  input  logic [cluster_pkg::StrbWidth-1:0]     req_be_i,
  input  logic [cluster_pkg::WordAddrWidth-1:0] req_addr_i,
  input  logic [cluster_pkg::DataWidth-1:0]     req_wdata_i,
  output logic                                  resp_valid_o,
  input  logic                                  resp_ready_i,
  output logic [cluster_pkg::DataWidth-1:0]     resp_rdata_o,
  // North
  output cluster_pkg::tcdm_req_t                master_north_req_o,
  output logic                                  master_north_req_valid_o,
  input  logic                                  master_north_req_ready_i,
  input  cluster_pkg::tcdm_resp_t               master_north_resp_i,
  input  logic                                  master_north_resp_valid_i,
  output logic                                  master_north_resp_ready_o,
  input  cluster_pkg::tcdm_req_t                slave_north_req_i,
  input  logic                                  slave_north_req_valid_i,
  output logic                                  slave_north_req_ready_o,
  output cluster_pkg::tcdm_resp_t               slave_north_resp_o,
  output logic                                  slave_north_resp_valid_o,
  input  logic                                  slave_north_resp_ready_i,
  // East
  output cluster_pkg::tcdm_req_t                master_east_req_o,
  output logic                                  master_east_req_valid_o,
  input  logic                                  master_east_req_ready_i,
  input  cluster_pkg::tcdm_resp_t               master_east_resp_i,
  input  logic                                  master_east_resp_valid_i,
  output logic                                  master_east_resp_ready_o,
  input  cluster_pkg::tcdm_req_t                slave_east_req_i,
  input  logic                                  slave_east_req_valid_i,
  output logic                                  slave_east_req_ready_o,
  output cluster_pkg::tcdm_resp_t               slave_east_resp_o,
  output logic                                  slave_east_resp_valid_o,
  input  logic                                  slave_east_resp_ready_i,
  // Northeast
  output cluster_pkg::tcdm_req_t                master_northeast_req_o,
  output logic                                  master_northeast_req_valid_o,
  input  logic                                  master_northeast_req_ready_i,
  input  cluster_pkg::tcdm_resp_t               master_northeast_resp_i,
  input  logic                                  master_northeast_resp_valid_i,
  output logic                                  master_northeast_resp_ready_o,
  input  cluster_pkg::tcdm_req_t                slave_northeast_req_i,
  input  logic                                  slave_northeast_req_valid_i,
  output logic                                  slave_northeast_req_ready_o,
  output cluster_pkg::tcdm_resp_t               slave_northeast_resp_o,
  output logic                                  slave_northeast_resp_valid_o,
  input  logic                                  slave_northeast_resp_ready_i
);
  import cluster_pkg::*;

  localparam int unsigned BankAddrWidth = $clog2(BankWords);

  // Core side
  logic       busy_q;
  logic       busy_d;
  logic       ready_q;
  logic       req_pend_q;
  tcdm_req_t  req_q;
  dir_e       tgt_q;
  logic       accept;
  logic       issue;

  // Bank side, requesters indexed by direction code
  logic [3:0] bank_req;
  logic [3:0] resp_ready;
  tcdm_req_t  bank_pl [4];
  tcdm_req_t  gnt_req;
  logic       can_grant;
  logic       gnt_valid;
  logic [1:0] gnt_idx;
  logic [1:0] rr_idx;
  logic [1:0] rr_q;
  logic       resp_pend_q;
  logic [1:0] resp_org_q;
  logic       resp_wen_q;
  logic       resp_accept;
  logic [DataWidth-1:0] bank_rdata;
  tcdm_resp_t bank_resp;

  // One outstanding request per core port
  assign accept      = req_valid_i & ready_q;
  assign busy_d      = accept | (busy_q & ~(resp_valid_o & resp_ready_i));
  assign req_ready_o = ready_q;

  // Remote requests leave on the master port picked by the address
  assign master_north_req_o           = req_q;
  assign master_east_req_o            = req_q;
  assign master_northeast_req_o       = req_q;
  assign master_north_req_valid_o     = req_pend_q & (tgt_q == DirNorth);
  assign master_east_req_valid_o      = req_pend_q & (tgt_q == DirEast);
  assign master_northeast_req_valid_o = req_pend_q & (tgt_q == DirNortheast);
  assign master_north_resp_ready_o     = resp_ready_i & (tgt_q == DirNorth);
  assign master_east_resp_ready_o      = resp_ready_i & (tgt_q == DirEast);
  assign master_northeast_resp_ready_o = resp_ready_i & (tgt_q == DirNortheast);

  // Hand-off of the pending request and return path to the core
  always_comb begin
    unique case (tgt_q)
      DirEast: begin
        issue        = master_east_req_ready_i;
        resp_valid_o = master_east_resp_valid_i;
        resp_rdata_o = master_east_resp_i.rdata;
      end
      DirNorth: begin
        issue        = master_north_req_ready_i;
        resp_valid_o = master_north_resp_valid_i;
        resp_rdata_o = master_north_resp_i.rdata;
      end
      DirNortheast: begin
        issue        = master_northeast_req_ready_i;
        resp_valid_o = master_northeast_resp_valid_i;
        resp_rdata_o = master_northeast_resp_i.rdata;
      end
      default: begin
        issue        = gnt_valid & (gnt_idx == DirLocal);
        resp_valid_o = resp_pend_q & (resp_org_q == DirLocal);
        resp_rdata_o = bank_resp.rdata;
      end
    endcase
  end

  assign bank_req = {slave_northeast_req_valid_i, slave_north_req_valid_i,
                     slave_east_req_valid_i, req_pend_q & (tgt_q == DirLocal)};
  assign bank_pl[DirLocal]     = req_q;
  assign bank_pl[DirEast]      = slave_east_req_i;
  assign bank_pl[DirNorth]     = slave_north_req_i;
  assign bank_pl[DirNortheast] = slave_northeast_req_i;

  // Back-pressure: a held response blocks the next grant
  assign resp_ready  = {slave_northeast_resp_ready_i, slave_north_resp_ready_i,
                        slave_east_resp_ready_i, resp_ready_i};
  assign resp_accept = resp_pend_q & resp_ready[resp_org_q];
  assign can_grant   = ~resp_pend_q | resp_accept;

  // Round-robin, search starts just after the last winner
  always_comb begin
    gnt_valid = 1'b0;
    gnt_idx   = rr_q;
    rr_idx    = rr_q;
    for (int i = 1; i <= 4; i++) begin
      rr_idx = rr_q + 2'(i);
      if (can_grant && !gnt_valid && bank_req[rr_idx]) begin
        gnt_valid = 1'b1;
        gnt_idx   = rr_idx;
      end
    end
  end

  assign gnt_req = bank_pl[gnt_idx];

  assign slave_east_req_ready_o      = gnt_valid & (gnt_idx == DirEast);
  assign slave_north_req_ready_o     = gnt_valid & (gnt_idx == DirNorth);
  assign slave_northeast_req_ready_o = gnt_valid & (gnt_idx == DirNortheast);

  // Writes answer with zero
  assign bank_resp.rdata = resp_wen_q ? '0 : bank_rdata;
  assign slave_east_resp_o            = bank_resp;
  assign slave_north_resp_o           = bank_resp;
  assign slave_northeast_resp_o       = bank_resp;
  assign slave_east_resp_valid_o      = resp_pend_q & (resp_org_q == DirEast);
  assign slave_north_resp_valid_o     = resp_pend_q & (resp_org_q == DirNorth);
  assign slave_northeast_resp_valid_o = resp_pend_q & (resp_org_q == DirNortheast);

  tcdm_bank #(
    .BankWords(BankWords)
  ) i_bank (
    .clk_i  (clk_i                               ),
    .req_i  (gnt_valid                           ),
    .wen_i  (gnt_req.wen                         ),
    .be_i   (gnt_req.be                          ),
    .addr_i (gnt_req.offset[BankAddrWidth-1:0]   ),
    .wdata_i(gnt_req.wdata                       ),
    .rdata_o(bank_rdata                          )
  );

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q      <= 1'b0;
      ready_q     <= 1'b0;
      req_pend_q  <= 1'b0;
      tgt_q       <= DirLocal;
      rr_q        <= 2'd0;
      resp_pend_q <= 1'b0;
    end else begin
      busy_q  <= busy_d;
      ready_q <= ~busy_d;
      if (accept) begin
        req_pend_q <= 1'b1;
        tgt_q      <= dir_e'(req_addr_i[WordAddrWidth-1 -: GroupIdWidth] ^ group_id_i);
      end else if (issue) begin
        req_pend_q <= 1'b0;
      end
      if (gnt_valid) begin
        rr_q        <= gnt_idx;
        resp_pend_q <= 1'b1;
      end else if (resp_accept) begin
        resp_pend_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= '{wen:    req_wen_i,
                 be:     req_be_i,
                 offset: req_addr_i[OffsetWidth-1:0],
                 wdata:  req_wdata_i};
    end
    if (gnt_valid) begin
      resp_org_q <= gnt_idx;
      resp_wen_q <= gnt_req.wen;
    end
  end

endmodule : cluster_group

// File: hdl/cluster.sv
// Cluster top level: reset generator, four groups and the register slices of the XOR links
`timescale 1ns/1ps

module cluster #(
  parameter int unsigned BankWords = 256
) (
  input  logic                                                          clk_i,
  input  logic                                                          rst_n_i,
  input  logic                                                          testmode_i,
  input  logic [cluster_pkg::NumGroups-1:0]                             req_valid_i,
  output logic [cluster_pkg::NumGroups-1:0]                             req_ready_o,
  input  logic [cluster_pkg::NumGroups-1:0]                             req_wen_i,
  input  logic [cluster_pkg::NumGroups-1:0][cluster_pkg::StrbWidth-1:0] req_be_i,
  input  logic [cluster_pkg::NumGroups-1:0][cluster_pkg::WordAddrWidth-1:0] req_addr_i,
  input  logic [cluster_pkg::NumGroups-1:0][cluster_pkg::DataWidth-1:0] req_wdata_i,
  output logic [cluster_pkg::NumGroups-1:0]                             resp_valid_o,
  input  logic [cluster_pkg::NumGroups-1:0]                             resp_ready_i,
  output logic [cluster_pkg::NumGroups-1:0][cluster_pkg::DataWidth-1:0] resp_rdata_o
);
  import cluster_pkg::*;

  logic rst_n;

  rst_gen_bypass i_rst_gen (
    .clk_i     (clk_i     ),
    .rst_n_i   (rst_n_i   ),
    .testmode_i(testmode_i),
    .rst_n_o   (rst_n     )
  );

  // Group paths, second index is the direction code (east 1, north 2, northeast 3)
  tcdm_req_t  [NumGroups-1:0][3:1] mst_req;
  tcdm_resp_t [NumGroups-1:0][3:1] mst_resp;
  tcdm_req_t  [NumGroups-1:0][3:1] slv_req;
  tcdm_resp_t [NumGroups-1:0][3:1] slv_resp;
  logic       [NumGroups-1:0][3:1] mst_req_valid;
  logic       [NumGroups-1:0][3:1] mst_req_ready;
  logic       [NumGroups-1:0][3:1] mst_resp_valid;
  logic       [NumGroups-1:0][3:1] mst_resp_ready;
  logic       [NumGroups-1:0][3:1] slv_req_valid;
  logic       [NumGroups-1:0][3:1] slv_req_ready;
  logic       [NumGroups-1:0][3:1] slv_resp_valid;
  logic       [NumGroups-1:0][3:1] slv_resp_ready;

  for (genvar g = 0; g < NumGroups; g++) begin : gen_groups
    cluster_group #(
      .BankWords(BankWords)
    ) i_group (
      .clk_i                        (clk_i                          ),
      .rst_n_i                      (rst_n                          ),
      .group_id_i                   (GroupIdWidth'(g)               ),
      .req_valid_i                  (req_valid_i[g]                 ),
      .req_ready_o                  (req_ready_o[g]                 ),
      .req_wen_i                    (req_wen_i[g]                   ),
      .req_be_i                     (req_be_i[g]                    ),
      .req_addr_i                   (req_addr_i[g]                  ),
      .req_wdata_i                  (req_wdata_i[g]                 ),
      .resp_valid_o                 (resp_valid_o[g]                ),
      .resp_ready_i                 (resp_ready_i[g]                ),
      .resp_rdata_o                 (resp_rdata_o[g]                ),
      .master_north_req_o           (mst_req[g][DirNorth]           ),
      .master_north_req_valid_o     (mst_req_valid[g][DirNorth]     ),
      .master_north_req_ready_i     (mst_req_ready[g][DirNorth]     ),
      .master_north_resp_i          (mst_resp[g][DirNorth]          ),
      .master_north_resp_valid_i    (mst_resp_valid[g][DirNorth]    ),
      .master_north_resp_ready_o    (mst_resp_ready[g][DirNorth]    ),
      .slave_north_req_i            (slv_req[g][DirNorth]           ),
      .slave_north_req_valid_i      (slv_req_valid[g][DirNorth]     ),
      .slave_north_req_ready_o      (slv_req_ready[g][DirNorth]     ),
      .slave_north_resp_o           (slv_resp[g][DirNorth]          ),
      .slave_north_resp_valid_o     (slv_resp_valid[g][DirNorth]    ),
      .slave_north_resp_ready_i     (slv_resp_ready[g][DirNorth]    ),
      .master_east_req_o            (mst_req[g][DirEast]            ),
      .master_east_req_valid_o      (mst_req_valid[g][DirEast]      ),
      .master_east_req_ready_i      (mst_req_ready[g][DirEast]      ),
      .master_east_resp_i           (mst_resp[g][DirEast]           ),
      .master_east_resp_valid_i     (mst_resp_valid[g][DirEast]     ),
      .master_east_resp_ready_o     (mst_resp_ready[g][DirEast]     ),
      .slave_east_req_i             (slv_req[g][DirEast]            ),
      .slave_east_req_valid_i       (slv_req_valid[g][DirEast]      ),
      .slave_east_req_ready_o       (slv_req_ready[g][DirEast]      ),
      .slave_east_resp_o            (slv_resp[g][DirEast]           ),
      .slave_east_resp_valid_o      (slv_resp_valid[g][DirEast]     ),
      .slave_east_resp_ready_i      (slv_resp_ready[g][DirEast]     ),
      .master_northeast_req_o       (mst_req[g][DirNortheast]       ),
      .master_northeast_req_valid_o (mst_req_valid[g][DirNortheast] ),
      .master_northeast_req_ready_i (mst_req_ready[g][DirNortheast] ),
      .master_northeast_resp_i      (mst_resp[g][DirNortheast]      ),
      .master_northeast_resp_valid_i(mst_resp_valid[g][DirNortheast]),
      .master_northeast_resp_ready_o(mst_resp_ready[g][DirNortheast]),
      .slave_northeast_req_i        (slv_req[g][DirNortheast]       ),
      .slave_northeast_req_valid_i  (slv_req_valid[g][DirNortheast] ),
      .slave_northeast_req_ready_o  (slv_req_ready[g][DirNortheast] ),
      .slave_northeast_resp_o       (slv_resp[g][DirNortheast]      ),
      .slave_northeast_resp_valid_o (slv_resp_valid[g][DirNortheast]),
      .slave_northeast_resp_ready_i (slv_resp_ready[g][DirNortheast])
    );

    for (genvar d = 1; d < 4; d++) begin : gen_links
      // Request goes to group g^d, its response comes back on the same direction
      link_reg #(
        .payload_t(tcdm_req_t)
      ) i_req_link (
        .clk_i  (clk_i                 ),
        .rst_n_i(rst_n                 ),
        .valid_i(mst_req_valid[g][d]   ),
        .ready_o(mst_req_ready[g][d]   ),
        .data_i (mst_req[g][d]         ),
        .valid_o(slv_req_valid[g ^ d][d]),
        .ready_i(slv_req_ready[g ^ d][d]),
        .data_o (slv_req[g ^ d][d]     )
      );

      link_reg #(
        .payload_t(tcdm_resp_t)
      ) i_resp_link (
        .clk_i  (clk_i                  ),
        .rst_n_i(rst_n                  ),
        .valid_i(slv_resp_valid[g ^ d][d]),
        .ready_o(slv_resp_ready[g ^ d][d]),
        .data_i (slv_resp[g ^ d][d]     ),
        .valid_o(mst_resp_valid[g][d]   ),
        .ready_i(mst_resp_ready[g][d]   ),
        .data_o (mst_resp[g][d]         )
      );
    end : gen_links
  end : gen_groups

endmodule : cluster

// File: sim/tb_clk_gen.sv
// Testbench clock and power-on reset, instantiated once by the cluster testbench
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned ClkPeriod   = 20,
  parameter int unsigned ResetCycles = 16,
  parameter int unsigned DriveDelay  = 2
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(ClkPeriod / 2) clk_o = ~clk_o;
  end

  // Release lines up with the stimulus drive point
  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #DriveDelay rst_n_o = 1'b1;
  end

endmodule : tb_clk_gen

// File: sim/tb_cluster.sv
// Self-checking testbench for the cluster, run as the top module of the simulation
`timescale 1ns/1ps

module tb_cluster;
  import cluster_pkg::*;

  localparam int unsigned BankWords     = 256;
  localparam int unsigned BankAddrWidth = $clog2(BankWords);
  localparam int unsigned ClkPeriod     = 20;
  localparam int unsigned ResetCycles   = 16;
  localparam int unsigned DriveDelay    = 2;
  // Word window per bank used by the tests
  localparam int unsigned WinWords      = 16;
  localparam int unsigned PartialCount  = 8;
  localparam int unsigned RandomCount   = 60;
  localparam int unsigned TxnPerPort    = 2 * WinWords + 6 + 2 * PartialCount + RandomCount;
  localparam int unsigned TotalTxn      = NumGroups * TxnPerPort;
  localparam int unsigned TimeoutCycles = ResetCycles + 200 * TotalTxn;

  logic clk;
  logic rst_n;
  logic testmode;
  logic [NumGroups-1:0]                    req_valid;
  logic [NumGroups-1:0]                    req_ready;
  logic [NumGroups-1:0]                    req_wen;
  logic [NumGroups-1:0][StrbWidth-1:0]     req_be;
  logic [NumGroups-1:0][WordAddrWidth-1:0] req_addr;
  logic [NumGroups-1:0][DataWidth-1:0]     req_wdata;
  logic [NumGroups-1:0]                    resp_valid;
  logic [NumGroups-1:0]                    resp_ready;
  logic [NumGroups-1:0][DataWidth-1:0]     resp_rdata;

  // Reference model and per-word locks against racing ports
  logic [DataWidth-1:0]     ref_mem [NumGroups*BankWords];
  bit                       wr_busy [NumGroups*BankWords];
  int                       rd_cnt  [NumGroups*BankWords];
  logic [DataWidth-1:0]     exp_rdata [NumGroups];
  logic [WordAddrWidth-1:0] exp_addr  [NumGroups];
  logic                     exp_wen   [NumGroups];
  int                       exp_idx   [NumGroups];
  bit                       outstanding [NumGroups];
  logic [31:0]              rng_state [2*NumGroups];

  tb_clk_gen #(
    .ClkPeriod  (ClkPeriod  ),
    .ResetCycles(ResetCycles),
    .DriveDelay (DriveDelay )
  ) i_clk_gen (
    .clk_o  (clk  ),
    .rst_n_o(rst_n)
  );

  cluster #(
    .BankWords(BankWords)
  ) dut0 (
    .clk_i       (clk       ),
    .rst_n_i     (rst_n     ),
    .testmode_i  (testmode  ),
    .req_valid_i (req_valid ),
    .req_ready_o (req_ready ),
    .req_wen_i   (req_wen   ),
    .req_be_i    (req_be    ),
    .req_addr_i  (req_addr  ),
    .req_wdata_i (req_wdata ),
    .resp_valid_o(resp_valid),
    .resp_ready_i(resp_ready),
    .resp_rdata_o(resp_rdata)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_random(input int s);
    rng_state[s] = xorshift32(rng_state[s]);
    return rng_state[s];
  endfunction

  // Group bits on top and alias bits above the bank depth
  function automatic logic [WordAddrWidth-1:0] make_addr(input int grp, input int word,
                                                         input logic [9:0] upper);
    int unsigned off;
    off = (int'(upper) << BankAddrWidth) | word;
    return {GroupIdWidth'(grp), OffsetWidth'(off)};
  endfunction

  function automatic int word_index(input logic [WordAddrWidth-1:0] addr);
    return int'(addr[WordAddrWidth-1 -: GroupIdWidth]) * BankWords
           + int'(addr[OffsetWidth-1:0]) % BankWords;
  endfunction

  // Writes merge the enabled bytes and answer zero
  function automatic logic [DataWidth-1:0] ref_access(input logic [WordAddrWidth-1:0] addr,
                                                      input logic wen,
                                                      input logic [StrbWidth-1:0] be,
                                                      input logic [DataWidth-1:0] wdata);
    int idx;
    idx = word_index(addr);
    if (!wen) begin
      return ref_mem[idx];
    end
    for (int b = 0; b < StrbWidth; b++) begin
      if (be[b]) begin
        ref_mem[idx][8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return '0;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic next_drive_slot();
    @(posedge clk);
    #DriveDelay;
  endtask

  // Starts at a drive slot and returns at the drive slot after acceptance
  task automatic do_txn(input int p, input logic wen, input logic [StrbWidth-1:0] be,
                        input logic [WordAddrWidth-1:0] addr, input logic [DataWidth-1:0] wdata);
    int idx;
    idx = word_index(addr);
    while (!req_ready[p] || wr_busy[idx] || (wen && rd_cnt[idx] != 0)) begin
      next_drive_slot();
    end
    if (wen) begin
      wr_busy[idx] = 1'b1;
    end else begin
      rd_cnt[idx]++;
    end
    req_valid[p] = 1'b1;
    req_wen[p]   = wen;
    req_be[p]    = be;
    req_addr[p]  = addr;
    req_wdata[p] = wdata;
    do @(negedge clk); while (!req_ready[p]);
    exp_addr[p]    = addr;
    exp_wen[p]     = wen;
    exp_idx[p]     = idx;
    exp_rdata[p]   = ref_access(addr, wen, be, wdata);
    outstanding[p] = 1'b1;
    next_drive_slot();
    req_valid[p] = 1'b0;
  endtask

  task automatic check_responses(input int p);
    forever begin
      @(negedge clk);
      if (resp_valid[p] && resp_ready[p]) begin
        assert (outstanding[p])
          else report_failure($sformatf("Port %0d returned a response with no request open", p));
        assert (resp_rdata[p] === exp_rdata[p])
          else report_failure($sformatf("[ERROR] %0t port %0d addr %h: rdata %h, expected %h",
                                        $time, p, exp_addr[p], resp_rdata[p], exp_rdata[p]));
        if (exp_wen[p]) begin
          wr_busy[exp_idx[p]] = 1'b0;
        end else begin
          rd_cnt[exp_idx[p]]--;
        end
        outstanding[p] = 1'b0;
      end
    end
  endtask

  // Random back-pressure with ready three cycles in four
  task automatic drive_resp_ready(input int p);
    logic [31:0] r;
    forever begin
      next_drive_slot();
      r = next_random(NumGroups + p);
      resp_ready[p] = (r[1:0] != 2'b00);
    end
  endtask

  task automatic port_phase(input int ph, input int p);
    logic [31:0] r;
    logic [WordAddrWidth-1:0] addr;
    int word;
    case (ph)
      // Whole window of the own bank
      2: begin
        for (int w = 0; w < WinWords; w++) begin
          r = next_random(p);
          do_txn(p, 1'b1, '1, make_addr(p, w, r[9:0]), next_random(p));
        end
        for (int w = 0; w < WinWords; w++) begin
          r = next_random(p);
          do_txn(p, 1'b0, '1, make_addr(p, w, r[9:0]), '0);
        end
      end
      // One word in each partner group read back through another alias
      3: begin
        for (int d = 1; d < 4; d++) begin
          r = next_random(p);
          word = (int'(r[11:10]) << 2) | p;
          do_txn(p, 1'b1, '1, make_addr(p ^ d, word, r[9:0]), next_random(p));
          do_txn(p, 1'b0, '1, make_addr(p ^ d, word, r[21:12]), '0);
        end
      end
      4: begin
        for (int i = 0; i < PartialCount; i++) begin
          r = next_random(p);
          addr = make_addr(p, (int'(r[11:10]) << 2) | p, r[9:0]);
          do_txn(p, 1'b1, r[15:12], addr, next_random(p));
          do_txn(p, 1'b0, '1, addr, '0);
        end
      end
      // Writes stay in the port's slice and reads go anywhere in the window
      default: begin
        for (int i = 0; i < RandomCount; i++) begin
          r = next_random(p);
          repeat (r[21:20]) next_drive_slot();
          word = r[0] ? ((int'(r[4:3]) << 2) | p) : int'(r[6:3]);
          do_txn(p, r[0], r[0] ? r[19:16] : 4'hF, make_addr(r[2:1], word, r[15:6]),
                 next_random(p));
        end
      end
    endcase
    while (outstanding[p]) begin
      next_drive_slot();
    end
  endtask

  task automatic run_phase(input int ph);
    fork
      port_phase(ph, 0);
      port_phase(ph, 1);
      port_phase(ph, 2);
      port_phase(ph, 3);
    join
  endtask

  initial begin : watchdog
    #(TimeoutCycles * ClkPeriod);
    report_failure($sformatf("Timeout: the run did not finish within %0d cycles", TimeoutCycles));
  end

  initial begin : main
    logic [31:0] seed;
    testmode   = 1'b0;
    req_valid  = '0;
    req_wen    = '0;
    req_be     = '0;
    req_addr   = '0;
    req_wdata  = '0;
    resp_ready = '0;
    seed = 32'h2951;
    for (int s = 0; s < 2 * NumGroups; s++) begin
      seed = xorshift32(seed);
      rng_state[s] = seed;
    end

    // Quiet through reset and the two release cycles before ready rises everywhere
    do begin
      @(negedge clk);
      assert (resp_valid == '0 && req_ready == '0)
        else report_failure($sformatf("[ERROR] %0t outputs active in reset: valid %b ready %b",
                                      $time, resp_valid, req_ready));
    end while (!rst_n);
    repeat (2) begin
      @(negedge clk);
      assert (resp_valid == '0 && req_ready == '0)
        else report_failure($sformatf("[ERROR] %0t outputs active before release", $time));
    end
    @(negedge clk);
    assert (resp_valid == '0 && req_ready == '1)
      else report_failure($sformatf("[ERROR] %0t after release: valid %b ready %b, want 0000 1111",
                                    $time, resp_valid, req_ready));

    fork
      check_responses(0);
      check_responses(1);
      check_responses(2);
      check_responses(3);
      drive_resp_ready(0);
      drive_resp_ready(1);
      drive_resp_ready(2);
      drive_resp_ready(3);
    join_none

    next_drive_slot();
    for (int ph = 2; ph <= 5; ph++) begin
      run_phase(ph);
    end

    $display("Test completed successfully");
    $finish;
  end

endmodule : tb_cluster

// File: sources.f
hdl/cluster_pkg.sv
hdl/rst_gen_bypass.sv
hdl/tcdm_bank.sv
hdl/link_reg.sv
hdl/cluster_group.sv
hdl/cluster.sv
sim/tb_clk_gen.sv
sim/tb_cluster.sv
